/* rtl/fetchPkg.sv */
// Shared definitions for the instruction-fetch subsystem.
// Covers the kernel-control encoding from coprocessor 0, the exception
// code field, and the opcode and function constants used for
// next-PC classification.

package fetchPkg;

    // kernel control request from coprocessor 0
    typedef enum logic [1:0] {
        kNone  = 2'd0,
        kEntry = 2'd1,
        kEret  = 2'd2
    } kCtrlT;

    // exception code as carried in the cause register
    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdel = 5'd4
    } excCodeT;

    // primary opcode field, instr[31:26]
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opRegimm  = 6'h01;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opBlez    = 6'h06;
    localparam logic [5:0] opBgtz    = 6'h07;

    // function field of special instructions, instr[5:0]
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnJalr = 6'h09;

    // Field positions within an instruction word, for reference:
    //   opcode  [31:26]
    //   target  [25:0]   jump immediate, word address
    //   imm16   [15:0]   branch offset, in words
    //   funct   [5:0]
    // The regimm group (bltz, bgez and their link forms) is classified
    // as a branch as a whole; decCmp carries the actual outcome.

endpackage

/* rtl/fetchStage.sv */
// Fetch stage: program counter, address range and alignment check,
// single outstanding memory read, and the output slot to decode.
// Illegal addresses fill the slot with an address-error entry
// without touching memory.

module fetchStage
    import fetchPkg::*;
#(
    parameter logic [31:0] textBase  = 32'h0000_3000,
    parameter int          textWords = 1024,
    localparam int         memAddrBits = $clog2(textWords)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [31:0]            nextPc,
    input  logic                   isJump,
    input  logic                   fetchReqReady,
    input  logic [31:0]            memRdata,
    input  logic                   outReady,
    output logic [31:0]            pc,
    output logic                   fetchReqValid,
    output logic [memAddrBits-1:0] fetchReqAddr,
    output logic                   outValid,
    output logic [31:0]            outInstr,
    output logic [31:0]            outPc,
    output excCodeT                outExc,
    output logic                   outDelaySlot
);

    localparam logic [31:0] textBytes = 32'(textWords * 4);

    logic [31:0] offset;
    logic        legal;
    logic        slotFree;
    logic        inFlight;
    logic        reqFire;
    logic        addrErr;
    logic        writeSlot;

    // below textBase the subtraction wraps to a large offset
    assign offset   = pc - textBase;
    assign legal    = (offset < textBytes) && (pc[1:0] == 2'b00);
    assign slotFree = !outValid || outReady;

    assign fetchReqValid = legal && slotFree && !inFlight;
    assign fetchReqAddr  = offset[memAddrBits+1:2];
    assign reqFire       = fetchReqValid && fetchReqReady;

    assign addrErr   = !legal && slotFree && !inFlight;
    assign writeSlot = inFlight || addrErr;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= textBase;
            inFlight <= 1'b0;
            outValid <= 1'b0;
        end else begin
            // read data is back one cycle after the grant
            inFlight <= reqFire;
            if (writeSlot) begin
                outValid <= 1'b1;
                pc       <= nextPc;
            end else if (outReady) begin
                outValid <= 1'b0;
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (writeSlot) begin
            outPc        <= pc;
            outDelaySlot <= isJump;
            if (inFlight) begin
                outInstr <= memRdata;
                outExc   <= excNone;
            end else begin
                outInstr <= '0;
                outExc   <= excAdel;
            end
        end
    end

    // a stalled slot keeps its entry until decode takes it
    assert property (@(posedge clk) disable iff (reset)
        outValid && !outReady |=> outValid && $stable(outInstr) && $stable(outPc)
            && $stable(outExc) && $stable(outDelaySlot))
        else $error("fetch slot changed while stalled");

    // a request blocked by the loader stays up with the same address
    assert property (@(posedge clk) disable iff (reset)
        fetchReqValid && !fetchReqReady |=> fetchReqValid && $stable(fetchReqAddr))
        else $error("blocked fetch request dropped or changed its address");

endmodule

/* rtl/fetchTop.sv */
// Top level of the instruction-fetch subsystem.
// Connects fetch stage, next-PC logic, memory arbiter and
// instruction memory, and passes the address map down.

module fetchTop
    import fetchPkg::*;
#(
    parameter logic [31:0] textBase    = 32'h0000_3000,
    parameter int          textWords   = 1024,
    parameter logic [31:0] kernelEntry = 32'h0000_3800,
    localparam int         memAddrBits = $clog2(textWords)
) (
    input  logic                   clk,
    input  logic                   reset,
    // program loader
    input  logic                   loadValid,
    output logic                   loadReady,
    input  logic [memAddrBits-1:0] loadAddr,
    input  logic [31:0]            loadData,
    // decode stage and coprocessor 0
    input  logic [31:0]            decInstr,
    input  logic                   decCmp,
    input  logic [31:0]            decJmpReg,
    input  kCtrlT                  kCtrl,
    input  logic [31:0]            epc,
    // fetch output to decode
    output logic                   outValid,
    input  logic                   outReady,
    output logic [31:0]            outInstr,
    output logic [31:0]            outPc,
    output excCodeT                outExc,
    output logic                   outDelaySlot
);

    logic [31:0]            pc;
    logic [31:0]            nextPc;
    logic                   isJump;
    logic                   fetchReqValid;
    logic                   fetchReqReady;
    logic [memAddrBits-1:0] fetchReqAddr;
    logic                   memEn;
    logic                   memWe;
    logic [memAddrBits-1:0] memAddr;
    logic [31:0]            memWdata;
    logic [31:0]            memRdata;

    fetchStage #(
        .textBase(textBase),
        .textWords(textWords)
    ) fetch (
        .clk(clk),
        .reset(reset),
        .nextPc(nextPc),
        .isJump(isJump),
        .fetchReqReady(fetchReqReady),
        .memRdata(memRdata),
        .outReady(outReady),
        .pc(pc),
        .fetchReqValid(fetchReqValid),
        .fetchReqAddr(fetchReqAddr),
        .outValid(outValid),
        .outInstr(outInstr),
        .outPc(outPc),
        .outExc(outExc),
        .outDelaySlot(outDelaySlot)
    );

    nextPcLogic #(
        .kernelEntry(kernelEntry)
    ) npc (
        .pc(pc),
        .decInstr(decInstr),
        .decCmp(decCmp),
        .decJmpReg(decJmpReg),
        .kCtrl(kCtrl),
        .epc(epc),
        .nextPc(nextPc),
        .isJump(isJump)
    );

    memArbiter #(
        .textWords(textWords)
    ) arb (
        .loadValid(loadValid),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .fetchReqValid(fetchReqValid),
        .fetchReqAddr(fetchReqAddr),
        .loadReady(loadReady),
        .fetchReqReady(fetchReqReady),
        .memEn(memEn),
        .memWe(memWe),
        .memAddr(memAddr),
        .memWdata(memWdata)
    );

    instrMem #(
        .textWords(textWords)
    ) imem (
        .clk(clk),
        .memEn(memEn),
        .memWe(memWe),
        .memAddr(memAddr),
        .memWdata(memWdata),
        .memRdata(memRdata)
    );

endmodule

/* rtl/instrMem.sv */
// Single-port synchronous instruction memory.
// Writes on an enabled write cycle; an enabled read registers the
// addressed word, giving one cycle of read latency.

module instrMem #(
    parameter int  textWords   = 1024,
    localparam int memAddrBits = $clog2(textWords)
) (
    input  logic                   clk,
    input  logic                   memEn,
    input  logic                   memWe,
    input  logic [memAddrBits-1:0] memAddr,
    input  logic [31:0]            memWdata,
    output logic [31:0]            memRdata
);

    logic [31:0] mem [textWords];

    // power-up image is all zero, the loader fills in the program
    initial begin
        for (int i = 0; i < textWords; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (memEn) begin
            if (memWe) begin
                mem[memAddr] <= memWdata;
            end else begin
                memRdata <= mem[memAddr];
            end
        end
    end

    // address comes through the arbiter from loader or fetch
    assert property (@(posedge clk) memEn |-> !$isunknown({memWe, memAddr}))
        else $error("memory access with unknown address or write enable");

endmodule

/* rtl/memArbiter.sv */
// Fixed-priority arbiter for the single instruction-memory port.
// The loader always wins; fetch reads proceed only while no load
// is pending. Steers address, write data and write enable from
// the granted requester.

module memArbiter #(
    parameter int  textWords   = 1024,
    localparam int memAddrBits = $clog2(textWords)
) (
    input  logic                   loadValid,
    input  logic [memAddrBits-1:0] loadAddr,
    input  logic [31:0]            loadData,
    input  logic                   fetchReqValid,
    input  logic [memAddrBits-1:0] fetchReqAddr,
    output logic                   loadReady,
    output logic                   fetchReqReady,
    output logic                   memEn,
    output logic                   memWe,
    output logic [memAddrBits-1:0] memAddr,
    output logic [31:0]            memWdata
);

    logic fetchGrant;

    // loader has priority
    assign loadReady     = loadValid;
    assign fetchReqReady = !loadValid;
    assign fetchGrant    = fetchReqValid && !loadValid;

    assign memEn = loadValid || fetchGrant;
    assign memWe = loadValid;

    always_comb begin
        if (loadValid) begin
            memAddr = loadAddr;
        end else begin
            memAddr = fetchReqAddr;
        end
    end

    // fetch never writes, so write data only comes from the loader
    assign memWdata = loadData;

endmodule

/* rtl/nextPcLogic.sv */
// Next-PC selection for the fetch stage.
// Classifies the decode-stage instruction as sequential, branch,
// immediate jump or register jump, builds the targets, and applies
// kernel entry, exception return and the terminal self-loop on top.

module nextPcLogic
    import fetchPkg::*;
#(
    parameter logic [31:0] kernelEntry = 32'h0000_3800
) (
    input  logic [31:0] pc,
    input  logic [31:0] decInstr,
    input  logic        decCmp,
    input  logic [31:0] decJmpReg,
    input  kCtrlT       kCtrl,
    input  logic [31:0] epc,
    output logic [31:0] nextPc,
    output logic        isJump
);

    typedef enum logic [1:0] {
        selSeq,
        selBranch,
        selJumpImm,
        selJumpReg
    } pcSelT;

    // last word before the kernel text, fetch parks here
    localparam logic [31:0] haltPc = kernelEntry - 32'd4;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic        isJumpReg;
    logic        isJumpImm;
    logic        isBranch;
    pcSelT       sel;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;

    assign opcode = decInstr[31:26];
    assign funct  = decInstr[5:0];

    assign isJumpReg = (opcode == opSpecial) && (funct == fnJr || funct == fnJalr);
    assign isJumpImm = (opcode == opJ) || (opcode == opJal);
    assign isBranch  = (opcode == opRegimm) || (opcode == opBeq) || (opcode == opBne)
                    || (opcode == opBlez) || (opcode == opBgtz);

    // the next fetch sits in the delay slot of any branch or jump
    assign isJump = isBranch || isJumpImm || isJumpReg;

    always_comb begin
        if (isJumpReg) begin
            sel = selJumpReg;
        end else if (isJumpImm) begin
            sel = selJumpImm;
        end else if (isBranch && decCmp) begin
            sel = selBranch;
        end else begin
            sel = selSeq;
        end
    end

    assign branchTarget = pc + {{14{decInstr[15]}}, decInstr[15:0], 2'b00};
    assign jumpTarget   = {pc[31:28], decInstr[25:0], 2'b00};

    always_comb begin
        if (kCtrl == kEntry) begin
            nextPc = kernelEntry;
        end else if (kCtrl == kEret) begin
            nextPc = {epc[31:2], 2'b00};
        end else if (pc == haltPc) begin
            nextPc = pc;
        end else begin
            case (sel)
                selJumpReg: nextPc = decJmpReg;
                selJumpImm: nextPc = jumpTarget;
                selBranch:  nextPc = branchTarget;
                default:    nextPc = pc + 32'd4;
            endcase
        end
    end

endmodule

/* sim.f */
rtl/fetchPkg.sv
rtl/nextPcLogic.sv
rtl/fetchStage.sv
rtl/memArbiter.sv
rtl/instrMem.sv
rtl/fetchTop.sv
verification/fetchTb.sv

/* verification/fetchTb.sv */
// Testbench for the instruction-fetch subsystem.
// Loads a program image, then walks a table of decode-stage inputs with
// random output hold-off, checking each fetch output against a reference
// next-PC model and a shadow copy of the instruction memory.

module fetchTb
    import fetchPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] textBase    = 32'h0000_3000;
    localparam int          textWords   = 1024;
    localparam logic [31:0] kernelEntry = 32'h0000_3800;
    localparam int          memAddrBits = $clog2(textWords);
    localparam int          imageWords  = 32;
    localparam int          nSteps      = 22;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   loadValid;
    logic                   loadReady;
    logic [memAddrBits-1:0] loadAddr;
    logic [31:0]            loadData;
    logic [31:0]            decInstr;
    logic                   decCmp;
    logic [31:0]            decJmpReg;
    kCtrlT                  kCtrl;
    logic [31:0]            epc;
    logic                   outValid;
    logic                   outReady;
    logic [31:0]            outInstr;
    logic [31:0]            outPc;
    excCodeT                outExc;
    logic                   outDelaySlot;

    logic [31:0] shadow [textWords];
    int          readCount;

    // one row per fetch output
    typedef struct packed {
        logic [31:0]            instr;
        logic                   cmp;
        logic [31:0]            jmpReg;
        kCtrlT                  kc;
        logic [31:0]            epc;
        logic                   loadEn;
        logic [memAddrBits-1:0] loadAddr;
        logic [31:0]            loadData;
        logic [3:0]             bpMax;
        excCodeT                expExc;
    } stepT;

    // instr, cmp, jmpReg, kCtrl, epc, loadEn, loadAddr, loadData, hold max, expected exc
    stepT steps [nSteps] = '{
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd0, excNone},
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd3, excNone},
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd0, excNone},
        '{{opBeq, 10'd0, 16'h0004}, 1'b1, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd2, excNone},
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd0, excNone},
        '{{opBne, 10'd0, 16'hfff8}, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd5, excNone},
        '{{opBgtz, 10'd0, 16'hfffd}, 1'b1, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd0, excNone},
        '{{opJ, 26'h0c10}, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd4, excNone},
        '{{opSpecial, 20'd0, fnJalr}, 1'b0, 32'h3010, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd0,
          excNone},
        '{{opJal, 26'h0c18}, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd7, excNone},
        '{{opSpecial, 20'd0, fnJr}, 1'b0, 32'h3062, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd0,
          excNone},
        '{{opSpecial, 20'd0, fnJr}, 1'b0, 32'h3004, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd3,
          excAdel},
        '{{opSpecial, 20'd0, fnJr}, 1'b0, 32'h5000, kNone, 32'h0, 1'b1, 10'd1, 32'h1357_9bdf,
          4'd2, excNone},
        '{32'h0, 1'b0, 32'h0, kEret, 32'h3027, 1'b0, 10'd0, 32'h0, 4'd0, excAdel},
        '{32'h0, 1'b0, 32'h0, kEntry, 32'h0, 1'b0, 10'd0, 32'h0, 4'd3, excNone},
        '{{opJ, 26'h0dff}, 1'b0, 32'h0, kNone, 32'h0, 1'b1, 10'd512, 32'h2468_ace0, 4'd0, excNone},
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b1, 10'd3, 32'h0f1e_2d3c, 4'd6, excNone},
        '{{opBeq, 10'd0, 16'h0005}, 1'b1, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd0, excNone},
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd2, excNone},
        '{32'h0, 1'b0, 32'h0, kEret, 32'h300c, 1'b0, 10'd0, 32'h0, 4'd0, excNone},
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b1, 10'd5, 32'h5a5a_0f0f, 4'd4, excNone},
        '{32'h0, 1'b0, 32'h0, kNone, 32'h0, 1'b0, 10'd0, 32'h0, 4'd1, excNone}
    };

    string names [nSteps] = '{
        "seq0", "seq1", "seq2", "beqTaken", "afterBeq", "bneNotTaken", "bgtzBack",
        "jumpFwd", "jalrBack", "jalFwd", "jrMisaligned", "adelMisaligned", "loadThenFetch",
        "adelRange", "eretTarget", "kernelEntry", "haltFirst", "haltBeq", "haltNop",
        "eretLeave", "rewritten", "seqAfter"
    };

    fetchTop #(
        .textBase(textBase),
        .textWords(textWords),
        .kernelEntry(kernelEntry)
    ) dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // loaded word mixes its index into both halves
    function automatic logic [31:0] imageWord(int idx);
        return {16'(idx) ^ 16'hc3a5, 16'(idx * 16'h0101)};
    endfunction

    // any branch or jump opcode puts the next fetch in a delay slot
    function automatic logic refIsJump(logic [31:0] instr);
        case (instr[31:26])
            opRegimm, opBeq, opBne, opBlez, opBgtz, opJ, opJal: return 1'b1;
            opSpecial: return instr[5:0] == fnJr || instr[5:0] == fnJalr;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] refNextPc(logic [31:0] curPc, stepT s);
        logic [5:0]  op;
        logic [31:0] np;
        op = s.instr[31:26];
        if (s.kc == kEntry) begin
            np = kernelEntry;
        end else if (s.kc == kEret) begin
            np = s.epc & ~32'h3;
        end else if (curPc == kernelEntry - 32'd4) begin
            np = curPc;
        end else if (op == opSpecial && refIsJump(s.instr)) begin
            np = s.jmpReg;
        end else if (op == opJ || op == opJal) begin
            np = {curPc[31:28], s.instr[25:0], 2'b00};
        end else if (refIsJump(s.instr) && s.cmp) begin
            // only branches are left at this point
            np = curPc + ({{16{s.instr[15]}}, s.instr[15:0]} << 2);
        end else begin
            np = curPc + 32'd4;
        end
        return np;
    endfunction

    task automatic checkWord(string what, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic checkExc(string what, excCodeT expected, excCodeT actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0d, actual %0d", what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic checkBit(string what, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %b, actual %b", what, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "%s mismatch", what);
        end
    endtask

    task automatic checkSlot(string name, logic [31:0] expPc, logic [31:0] expInstr,
                             excCodeT expExc, logic expDs);
        checkWord({name, " outPc"}, expPc, outPc);
        checkWord({name, " outInstr"}, expInstr, outInstr);
        checkExc({name, " outExc"}, expExc, outExc);
        checkBit({name, " outDelaySlot"}, expDs, outDelaySlot);
    endtask

    // decode inputs for one step, plus its loader write if any
    task automatic applyStep(int k);
        decInstr  <= steps[k].instr;
        decCmp    <= steps[k].cmp;
        decJmpReg <= steps[k].jmpReg;
        kCtrl     <= steps[k].kc;
        epc       <= steps[k].epc;
        if (steps[k].loadEn) begin
            loadValid <= 1'b1;
            loadAddr  <= steps[k].loadAddr;
            loadData  <= steps[k].loadData;
            shadow[steps[k].loadAddr] = steps[k].loadData;
        end
    endtask

    // fetch reads granted, counted at the edge that accepts them
    always @(posedge clk) begin
        if (!reset && dut.memEn && !dut.memWe) begin
            readCount++;
        end
    end

    initial begin
        #(nSteps * 64 * 40);
        $display("watchdog expired before all fetch outputs arrived");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] modelPc;
        logic [31:0] expInstr;
        logic [31:0] rngState;
        excCodeT     expExc;
        int          hold;

        reset     = 1'b1;
        loadValid = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        decInstr  = '0;
        decCmp    = 1'b0;
        decJmpReg = '0;
        kCtrl     = kNone;
        epc       = '0;
        outReady  = 1'b0;
        readCount = 0;
        modelPc   = textBase;
        rngState  = 32'h478ef5fe;
        for (int i = 0; i < textWords; i++) begin
            shadow[i] = '0;
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        applyStep(0);
        // loader holds the port, fetch stays parked at textBase
        for (int i = 0; i < imageWords; i++) begin
            loadValid <= 1'b1;
            loadAddr  <= memAddrBits'(i);
            loadData  <= imageWord(i);
            shadow[i] = imageWord(i);
            @(posedge clk);
        end
        loadValid <= 1'b0;

        for (int k = 0; k < nSteps; k++) begin
            @(negedge clk);
            while (!outValid) begin
                @(negedge clk);
            end
            expExc = steps[k].expExc;
            if (expExc == excNone) begin
                expInstr = shadow[memAddrBits'((modelPc - textBase) >> 2)];
            end else begin
                expInstr = '0;
            end
            checkSlot(names[k], modelPc, expInstr, expExc, refIsJump(steps[k].instr));
            checkWord({names[k], " memory reads"}, (expExc == excNone) ? 32'd1 : 32'd0,
                      readCount);
            readCount = 0;

            hold = 0;
            if (steps[k].bpMax != 0) begin
                rngState = xorshift(rngState);
                hold = int'(rngState % (steps[k].bpMax + 1));
            end
            // stalled slot keeps its entry
            repeat (hold) begin
                @(negedge clk);
                checkBit({names[k], " held outValid"}, 1'b1, outValid);
                checkSlot({names[k], " held"}, modelPc, expInstr, expExc,
                          refIsJump(steps[k].instr));
            end

            modelPc = refNextPc(modelPc, steps[k]);
            @(posedge clk);
            outReady <= 1'b1;
            if (k + 1 < nSteps) begin
                applyStep(k + 1);
            end
            @(negedge clk);
            if (k + 1 < nSteps && steps[k + 1].loadEn) begin
                checkBit({names[k + 1], " loadReady"}, 1'b1, loadReady);
            end
            @(posedge clk);
            outReady  <= 1'b0;
            loadValid <= 1'b0;
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule
